//--- hw/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Frame buffer geometry
`define SCREEN_W    160
`define SCREEN_H    120
`define FB_WORDS    (`SCREEN_W * `SCREEN_H)

`define TILE_SIZE   8
`define GRID_W      20      // Tiles across
`define GRID_H      15      // Tiles down
`define HOME_X      10
`define HOME_Y      7

// PS/2 set 2 make codes
`define KEY_UP      8'h1D
`define KEY_LEFT    8'h1C
`define KEY_DOWN    8'h1B
`define KEY_RIGHT   8'h23
`define KEY_START   8'h5A
`define KEY_QUIT    8'h76

// 4:4:4 RGB
`define COLOR_GREETING    12'h00F
`define COLOR_GAME_OVER   12'hF00
`define COLOR_BACKGROUND  12'h000
`define COLOR_PLAYER      12'hFF0

`endif

//--- hw/game_pkg.sv
package game_pkg;

    typedef logic [11:0] color_t;       // 4 bits per channel
    typedef logic [14:0] fb_addr_t;     // Row * SCREEN_W + column
    typedef logic [7:0]  scan_code_t;
    typedef logic [4:0]  tile_x_t;
    typedef logic [3:0]  tile_y_t;

    typedef enum logic [2:0] {
        DIR_NONE,
        DIR_UP,
        DIR_LEFT,
        DIR_DOWN,
        DIR_RIGHT
    } dir_t;

    typedef enum logic [1:0] {
        PHASE_GREETING,
        PHASE_PLAYING,
        PHASE_GAME_OVER
    } game_phase_t;

    // Sequencer steps, shared by all phases
    typedef enum logic [2:0] {
        STEP_FILL,
        STEP_FILL_WAIT,
        STEP_WAIT_START,
        STEP_MOVE,
        STEP_DRAW,
        STEP_DRAW_WAIT
    } frame_step_t;

endpackage

//--- hw/key_decode.sv
`include "game_defs.svh"

module key_decode import game_pkg::*; (
    input  logic       clock,
    input  logic       resetn,
    input  scan_code_t last_key_received,
    input  logic       key_strobe,
    input  logic       start_ack,
    input  logic       quit_ack,
    input  logic       move,
    output dir_t       pending_dir,
    output logic       start_pending,
    output logic       quit_pending
);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            pending_dir   <= DIR_NONE;
            start_pending <= 1'b0;
            quit_pending  <= 1'b0;
        end else begin
            // Acknowledges first, so a key on the same edge overrides them
            if (move)
                pending_dir <= DIR_NONE;
            if (quit_ack)
                quit_pending <= 1'b0;
            if (start_ack) begin
                // A new game starts with no stale requests
                start_pending <= 1'b0;
                quit_pending  <= 1'b0;
                pending_dir   <= DIR_NONE;
            end

            if (key_strobe) begin
                case (last_key_received)
                    `KEY_UP:    pending_dir <= DIR_UP;
                    `KEY_LEFT:  pending_dir <= DIR_LEFT;
                    `KEY_DOWN:  pending_dir <= DIR_DOWN;
                    `KEY_RIGHT: pending_dir <= DIR_RIGHT;
                    `KEY_START: start_pending <= 1'b1;
                    `KEY_QUIT:  quit_pending <= 1'b1;
                    default: ;  // Unknown codes dropped
                endcase
            end
        end
    end

endmodule

//--- hw/player_move.sv
`include "game_defs.svh"

module player_move import game_pkg::*; (
    input  logic    clock,
    input  logic    resetn,
    input  logic    home,
    input  logic    move,
    input  dir_t    pending_dir,
    output tile_x_t tile_x,
    output tile_y_t tile_y
);

    always_ff @(posedge clock) begin
        if (!resetn || home) begin
            tile_x <= tile_x_t'(`HOME_X);
            tile_y <= tile_y_t'(`HOME_Y);
        end else if (move) begin
            // One tile per move, blocked at the grid border
            case (pending_dir)
                DIR_UP: begin
                    if (tile_y != '0)
                        tile_y <= tile_y - 1'b1;
                end
                DIR_DOWN: begin
                    if (tile_y < tile_y_t'(`GRID_H - 1))
                        tile_y <= tile_y + 1'b1;
                end
                DIR_LEFT: begin
                    if (tile_x != '0)
                        tile_x <= tile_x - 1'b1;
                end
                DIR_RIGHT: begin
                    if (tile_x < tile_x_t'(`GRID_W - 1))
                        tile_x <= tile_x + 1'b1;
                end
                default: ;          // DIR_NONE stays put
            endcase
        end
    end

endmodule

//--- hw/pixel_writer.sv
`include "game_defs.svh"

module pixel_writer import game_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     fill_start,
    input  logic     tile_start,
    input  color_t   fill_color,
    input  tile_x_t  tile_x,
    input  tile_y_t  tile_y,
    output color_t   data,
    output fb_addr_t addr,
    output logic     wren,
    output logic     draw_done
);

    logic     fill_active;
    logic     tile_active;
    logic     fill_last;
    logic [5:0] tile_idx;       // Pixel on the port, row in [5:3], column in [2:0]
    logic [5:0] next_idx;
    fb_addr_t tile_base;
    fb_addr_t start_base;
    fb_addr_t next_tile_addr;

    // Top-left pixel of the tile
    assign start_base = fb_addr_t'(tile_y * (`TILE_SIZE * `SCREEN_W) + tile_x * `TILE_SIZE);

    assign next_idx       = tile_idx + 6'd1;
    assign next_tile_addr = fb_addr_t'(tile_base + next_idx[5:3] * `SCREEN_W + next_idx[2:0]);
    assign fill_last      = (addr == fb_addr_t'(`FB_WORDS - 1));

    // Job control
    always_ff @(posedge clock) begin
        if (!resetn) begin
            fill_active <= 1'b0;
            tile_active <= 1'b0;
            wren        <= 1'b0;
            draw_done   <= 1'b0;
        end else begin
            draw_done <= 1'b0;
            if (fill_start) begin
                fill_active <= 1'b1;
                tile_active <= 1'b0;
                wren        <= 1'b1;
            end else if (tile_start) begin
                fill_active <= 1'b0;
                tile_active <= 1'b1;
                wren        <= 1'b1;
            end else if (fill_active) begin
                if (fill_last) begin
                    fill_active <= 1'b0;
                    wren        <= 1'b0;
                end else if (addr == fb_addr_t'(`FB_WORDS - 2)) begin
                    draw_done <= 1'b1;  // Lines up with the final write
                end
            end else if (tile_active) begin
                if (tile_idx == 6'd63) begin
                    tile_active <= 1'b0;
                    wren        <= 1'b0;
                end else if (tile_idx == 6'd62) begin
                    draw_done <= 1'b1;
                end
            end
        end
    end

    // Write port payload
    always_ff @(posedge clock) begin
        if (fill_start) begin
            addr <= '0;
            data <= fill_color;
        end else if (tile_start) begin
            addr      <= start_base;
            tile_base <= start_base;
            tile_idx  <= '0;
            data      <= `COLOR_PLAYER;
        end else if (fill_active && !fill_last) begin
            addr <= addr + 1'b1;
        end else if (tile_active && tile_idx != 6'd63) begin
            tile_idx <= next_idx;
            addr     <= next_tile_addr;
        end
    end

endmodule

//--- hw/game_sequencer.sv
`include "game_defs.svh"

module game_sequencer import game_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic        start_pending,
    input  logic        quit_pending,
    input  logic        draw_done,
    output game_phase_t game_phase,
    output logic        start_ack,
    output logic        quit_ack,
    output logic        home,
    output logic        move,
    output logic        fill_start,
    output logic        tile_start,
    output color_t      fill_color
);

    frame_step_t step;

    // Each phase clears the screen in its own color
    always_comb begin
        case (game_phase)
            PHASE_PLAYING:   fill_color = `COLOR_BACKGROUND;
            PHASE_GAME_OVER: fill_color = `COLOR_GAME_OVER;
            default:         fill_color = `COLOR_GREETING;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            game_phase <= PHASE_GREETING;
            step       <= STEP_FILL;
            start_ack  <= 1'b0;
            quit_ack   <= 1'b0;
            home       <= 1'b0;
            move       <= 1'b0;
            fill_start <= 1'b0;
            tile_start <= 1'b0;
        end else begin
            // All strobes last one cycle
            start_ack  <= 1'b0;
            quit_ack   <= 1'b0;
            home       <= 1'b0;
            move       <= 1'b0;
            fill_start <= 1'b0;
            tile_start <= 1'b0;

            case (step)
                STEP_FILL: begin
                    fill_start <= 1'b1;
                    step       <= STEP_FILL_WAIT;
                end

                STEP_FILL_WAIT: begin
                    if (draw_done) begin
                        case (game_phase)
                            PHASE_PLAYING: step <= STEP_MOVE;
                            PHASE_GAME_OVER: begin
                                game_phase <= PHASE_GREETING;
                                step       <= STEP_FILL;
                            end
                            default: step <= STEP_WAIT_START;
                        endcase
                    end
                end

                // Greeting screen holds until start is pressed
                STEP_WAIT_START: begin
                    if (start_pending) begin
                        start_ack  <= 1'b1;
                        home       <= 1'b1;
                        game_phase <= PHASE_PLAYING;
                        step       <= STEP_FILL;
                    end
                end

                STEP_MOVE: begin
                    move <= 1'b1;       // Also clears the pending direction
                    step <= STEP_DRAW;
                end

                STEP_DRAW: begin
                    tile_start <= 1'b1; // Position already updated by now
                    step       <= STEP_DRAW_WAIT;
                end

                // End of frame, quit is only honoured here
                STEP_DRAW_WAIT: begin
                    if (draw_done) begin
                        if (quit_pending) begin
                            quit_ack   <= 1'b1;
                            game_phase <= PHASE_GAME_OVER;
                        end
                        step <= STEP_FILL;
                    end
                end

                default: step <= STEP_FILL;
            endcase
        end
    end

endmodule

//--- hw/game_top.sv
module game_top import game_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  scan_code_t  last_key_received,
    input  logic        key_strobe,
    output color_t      data,
    output fb_addr_t    addr,
    output logic        wren,
    output game_phase_t game_phase
);

    dir_t    pending_dir;
    logic    start_pending;
    logic    quit_pending;
    logic    start_ack;
    logic    quit_ack;
    logic    home;
    logic    move;
    logic    fill_start;
    logic    tile_start;
    logic    draw_done;
    color_t  fill_color;
    tile_x_t tile_x;
    tile_y_t tile_y;

    key_decode key_decode_i (
        .clock             (clock),
        .resetn            (resetn),
        .last_key_received (last_key_received),
        .key_strobe        (key_strobe),
        .start_ack         (start_ack),
        .quit_ack          (quit_ack),
        .move              (move),
        .pending_dir       (pending_dir),
        .start_pending     (start_pending),
        .quit_pending      (quit_pending)
    );

    game_sequencer game_sequencer_i (
        .clock         (clock),
        .resetn        (resetn),
        .start_pending (start_pending),
        .quit_pending  (quit_pending),
        .draw_done     (draw_done),
        .game_phase    (game_phase),
        .start_ack     (start_ack),
        .quit_ack      (quit_ack),
        .home          (home),
        .move          (move),
        .fill_start    (fill_start),
        .tile_start    (tile_start),
        .fill_color    (fill_color)
    );

    player_move player_move_i (
        .clock       (clock),
        .resetn      (resetn),
        .home        (home),
        .move        (move),
        .pending_dir (pending_dir),
        .tile_x      (tile_x),
        .tile_y      (tile_y)
    );

    // Only block that touches the frame buffer
    pixel_writer pixel_writer_i (
        .clock      (clock),
        .resetn     (resetn),
        .fill_start (fill_start),
        .tile_start (tile_start),
        .fill_color (fill_color),
        .tile_x     (tile_x),
        .tile_y     (tile_y),
        .data       (data),
        .addr       (addr),
        .wren       (wren),
        .draw_done  (draw_done)
    );

endmodule

//--- bench/game_sva.sv
`include "game_defs.svh"

module game_sva import game_pkg::*; (
    input logic        clock,
    input logic        resetn,
    input logic        wren,
    input fb_addr_t    addr,
    input color_t      data,
    input game_phase_t game_phase
);

    timeunit 1ns;
    timeprecision 1ps;

    int assert_failures = 0;    // Read by the testbench at the end

    wren_low_in_reset: assert property (@(posedge clock) !resetn |=> !wren)
        else begin
            assert_failures++;
            $error("wren high during reset");
        end

    addr_in_range: assert property (@(posedge clock) disable iff (!resetn)
        wren |-> addr < `FB_WORDS)
        else begin
            assert_failures++;
            $error("write address 0x%h beyond the frame buffer", addr);
        end

    phase_defined: assert property (@(posedge clock) disable iff (!resetn)
        game_phase inside {PHASE_GREETING, PHASE_PLAYING, PHASE_GAME_OVER})
        else begin
            assert_failures++;
            $error("game_phase holds undefined value 0x%h", game_phase);
        end

    // Only the four palette entries ever reach the RAM
    data_known_color: assert property (@(posedge clock) disable iff (!resetn)
        wren |-> data inside {`COLOR_GREETING, `COLOR_GAME_OVER,
                              `COLOR_BACKGROUND, `COLOR_PLAYER})
        else begin
            assert_failures++;
            $error("write data 0x%h is not a game color", data);
        end

endmodule

bind game_top game_sva game_sva_i (.*);

//--- bench/game_tb.sv
`include "game_defs.svh"

module game_tb import game_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // Room for 40 full-screen fills plus slack
    localparam int TIMEOUT_CYCLES = 40 * (`FB_WORDS + 100) + 1000;

    logic        clock;
    logic        resetn;
    scan_code_t  last_key_received;
    logic        key_strobe;
    color_t      data;
    fb_addr_t    addr;
    logic        wren;
    game_phase_t game_phase;

    int      errors;
    int      tests_passed;
    int      tests_failed;
    int      test_start_errors;
    int      cycle_count;
    tile_x_t exp_x;         // Expected player column
    tile_y_t exp_y;         // Expected player row

    game_top game_top_i (
        .clock             (clock),
        .resetn            (resetn),
        .last_key_received (last_key_received),
        .key_strobe        (key_strobe),
        .data              (data),
        .addr              (addr),
        .wren              (wren),
        .game_phase        (game_phase)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_phase(input string sig, input game_phase_t expected,
                               input game_phase_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected 0x%h, got 0x%h", sig, expected, actual);
        end
    endtask

    task automatic check_color(input string sig, input color_t expected, input color_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected 0x%h, got 0x%h", sig, expected, actual);
        end
    endtask

    task automatic check_addr(input string sig, input fb_addr_t expected, input fb_addr_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s expected 0x%h, got 0x%h", sig, expected, actual);
        end
    endtask

    // One-cycle key strobe
    task automatic press_key(input scan_code_t code);
        @(negedge clock);
        last_key_received = code;
        key_strobe        = 1'b1;
        @(negedge clock);
        key_strobe        = 1'b0;
    endtask

    task automatic random_wait();
        repeat ($urandom_range(20, 0)) @(negedge clock);
    endtask

    task automatic wait_for_write();
        do
            @(negedge clock);
        while (wren !== 1'b1);
    endtask

    task automatic expect_fill(input color_t color);
        int i;
        int start_errors;
        start_errors = errors;
        wait_for_write();
        for (i = 0; i < `FB_WORDS && errors == start_errors; i++) begin
            if (i > 0)
                @(negedge clock);
            if (wren !== 1'b1) begin
                errors++;
                $display("Fill with color 0x%h stopped after %0d of %0d writes",
                         color, i, `FB_WORDS);
            end else begin
                check_addr("addr", fb_addr_t'(i), addr);
                check_color("data", color, data);
            end
        end
    endtask

    // Row-major walk from the tile's top-left pixel
    task automatic expect_tile(input tile_x_t x, input tile_y_t y);
        int r;
        int c;
        int base;
        int start_errors;
        start_errors = errors;
        base = int'(y) * `TILE_SIZE * `SCREEN_W + int'(x) * `TILE_SIZE;
        wait_for_write();
        for (r = 0; r < `TILE_SIZE && errors == start_errors; r++) begin
            for (c = 0; c < `TILE_SIZE && errors == start_errors; c++) begin
                if (r > 0 || c > 0)
                    @(negedge clock);
                if (wren !== 1'b1) begin
                    errors++;
                    $display("Tile at (%0d, %0d) stopped after %0d of 64 writes",
                             x, y, r * `TILE_SIZE + c);
                end else begin
                    check_addr("addr", fb_addr_t'(base + r * `SCREEN_W + c), addr);
                    check_color("data", `COLOR_PLAYER, data);
                end
            end
        end
    endtask

    // No writes and greeting held
    task automatic expect_idle(input int cycles);
        int i;
        int start_errors;
        start_errors = errors;
        for (i = 0; i < cycles && errors == start_errors; i++) begin
            @(negedge clock);
            if (wren !== 1'b0) begin
                errors++;
                $display("Unexpected write at address 0x%h while waiting for start", addr);
            end
            check_phase("game_phase", PHASE_GREETING, game_phase);
        end
    endtask

    function automatic bit is_direction(input scan_code_t code);
        return code == `KEY_UP || code == `KEY_LEFT || code == `KEY_DOWN || code == `KEY_RIGHT;
    endfunction

    // Steps the model one tile unless the border blocks it
    function automatic void move_expected(input scan_code_t code);
        case (code)
            `KEY_UP:    if (exp_y > 0) exp_y = exp_y - 1'b1;
            `KEY_DOWN:  if (exp_y < `GRID_H - 1) exp_y = exp_y + 1'b1;
            `KEY_LEFT:  if (exp_x > 0) exp_x = exp_x - 1'b1;
            `KEY_RIGHT: if (exp_x < `GRID_W - 1) exp_x = exp_x + 1'b1;
            default: ;
        endcase
    endfunction

    // Keys go in while the background fill runs
    task automatic play_frame(input int num_keys, input scan_code_t first_key,
                              input scan_code_t second_key);
        scan_code_t dir_key;
        dir_key = 8'h00;
        if (num_keys >= 1 && is_direction(first_key))
            dir_key = first_key;
        if (num_keys >= 2 && is_direction(second_key))
            dir_key = second_key;   // Later key wins
        fork
            expect_fill(`COLOR_BACKGROUND);
            begin
                if (num_keys >= 1) begin
                    random_wait();
                    press_key(first_key);
                end
                if (num_keys >= 2) begin
                    random_wait();
                    press_key(second_key);
                end
            end
        join
        check_phase("game_phase", PHASE_PLAYING, game_phase);
        move_expected(dir_key);
        expect_tile(exp_x, exp_y);
    endtask

    task automatic finish_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    task automatic greeting_after_reset();
        check_phase("game_phase", PHASE_GREETING, game_phase);
        expect_fill(`COLOR_GREETING);
        check_phase("game_phase", PHASE_GREETING, game_phase);
        expect_idle(500);
        finish_test("reset_greeting");
    endtask

    task automatic ignore_codes_in_greeting();
        random_wait();
        press_key(8'h15);
        random_wait();
        press_key(`KEY_UP);
        random_wait();
        press_key(`KEY_LEFT);
        expect_idle(100);
        finish_test("ignored_codes");
    endtask

    // Stale direction keys from greeting must not move the player
    task automatic start_game();
        random_wait();
        press_key(`KEY_START);
        exp_x = `HOME_X;
        exp_y = `HOME_Y;
        play_frame(0, 8'h00, 8'h00);
        finish_test("start");
    endtask

    task automatic move_player();
        play_frame(1, `KEY_RIGHT, 8'h00);
        play_frame(0, 8'h00, 8'h00);
        play_frame(1, `KEY_UP, 8'h00);
        play_frame(2, `KEY_LEFT, `KEY_DOWN);
        finish_test("movement");
    endtask

    task automatic clamp_at_top_edge();
        repeat (8) play_frame(1, `KEY_UP, 8'h00);
        finish_test("edge_clamp");
    endtask

    task automatic quit_and_restart();
        play_frame(1, `KEY_QUIT, 8'h00);
        expect_fill(`COLOR_GAME_OVER);
        check_phase("game_phase", PHASE_GAME_OVER, game_phase);
        expect_fill(`COLOR_GREETING);
        check_phase("game_phase", PHASE_GREETING, game_phase);
        random_wait();
        press_key(`KEY_START);
        exp_x = `HOME_X;
        exp_y = `HOME_Y;
        play_frame(0, 8'h00, 8'h00);
        finish_test("quit_restart");
    endtask

    initial begin
        clock             = 1'b0;
        resetn            = 1'b0;
        last_key_received = '0;
        key_strobe        = 1'b0;
        errors            = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        cycle_count       = 0;
        exp_x             = `HOME_X;
        exp_y             = `HOME_Y;
        void'($urandom(55796));

        repeat (16) @(negedge clock);
        resetn = 1'b1;

        greeting_after_reset();
        ignore_codes_in_greeting();
        start_game();
        move_player();
        clamp_at_top_edge();
        quit_and_restart();

        if (game_top_i.game_sva_i.assert_failures != 0)
            $display("%0d assertion failures in the bound checker",
                     game_top_i.game_sva_i.assert_failures);
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && game_top_i.game_sva_i.assert_failures == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+hw
hw/game_pkg.sv
hw/key_decode.sv
hw/player_move.sv
hw/pixel_writer.sv
hw/game_sequencer.sv
hw/game_top.sv
bench/game_sva.sv
bench/game_tb.sv
